// ==== fe_pkg.sv ====
// Shared types and constants for the instruction-fetch front end.
// Every front-end block takes what it needs from here by a wildcard import.
package fe_pkg;

   // virtual fetch address, low 12 bits are the page offset
   typedef logic [31:0] vaddr_t;
   typedef logic [19:0] vpn_t;
   typedef logic [11:0] ppn_t;

   // physical address, ppn followed by the page offset
   typedef logic [23:0] paddr_t;

   typedef logic [31:0] instr_t;

   // backend command opcodes
   typedef enum logic [1:0] {
      FE_OP_REDIRECT     = 2'd0,
      FE_OP_ITLB_FILL    = 2'd1,
      FE_OP_ICACHE_FENCE = 2'd2
   } fe_opcode_e;

   // kind of a fetch queue entry
   typedef enum logic {
      FE_EXC_NONE      = 1'b0,
      FE_EXC_ITLB_MISS = 1'b1
   } fe_exc_e;

   localparam int LINE_WORDS = 4;

   // refill beat index, one beat per line word
   typedef logic [1:0] beat_t;

endpackage

// ==== fe_beat_counter.sv ====
// Counts the beats of a line refill.
// Cleared at the start of a refill, stepped once per memory response.
`timescale 1ns/1ns

module fe_beat_counter
   import fe_pkg::*;
(
   input  logic  clk_i,
   input  logic  rst_n_i,
   input  logic  clear_i,
   input  logic  inc_i,
   output beat_t beat_o,
   output logic  last_o
);

   beat_t beat_q;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         beat_q <= '0;
      end else if (clear_i) begin
         beat_q <= '0;
      end else if (inc_i) begin
         beat_q <= beat_q + 1'b1;
      end
   end

   assign beat_o = beat_q;
   assign last_o = (beat_q == beat_t'(LINE_WORDS - 1));

endmodule

// ==== fe_refill_fsm.sv ====
// Line refill controller on the memory request/response port.
// Sends one word request per beat and waits for its response before the
// next. Backend commands are held off while a miss is pending or in refill.
`timescale 1ns/1ns

module fe_refill_fsm
   import fe_pkg::*;
(
   input  logic   clk_i,
   input  logic   rst_n_i,
   input  logic   miss_i,
   input  paddr_t miss_paddr_i,
   input  logic   mem_req_ready_i,
   input  logic   mem_resp_v_i,
   input  beat_t  beat_i,
   input  logic   beat_last_i,
   output logic   mem_req_v_o,
   output paddr_t mem_req_addr_o,
   output logic   beat_clear_o,
   output logic   beat_inc_o,
   output logic   refill_done_o,
   output logic   cmd_ready_o
);

   typedef enum logic [1:0] {
      IDLE,
      REQ,
      WAIT,
      DONE
   } refill_state_e;

   refill_state_e state_q;
   refill_state_e state_d;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   always_comb begin
      state_d       = state_q;
      mem_req_v_o   = 1'b0;
      beat_clear_o  = 1'b0;
      beat_inc_o    = 1'b0;
      refill_done_o = 1'b0;
      case (state_q)
         IDLE: begin
            if (miss_i) begin
               beat_clear_o = 1'b1;
               state_d      = REQ;
            end
         end
         REQ: begin
            mem_req_v_o = 1'b1;
            if (mem_req_ready_i) begin
               state_d = WAIT;
            end
         end
         WAIT: begin
            if (mem_resp_v_i) begin
               beat_inc_o = 1'b1;
               state_d    = beat_last_i ? DONE : REQ;
            end
         end
         DONE: begin
            refill_done_o = 1'b1;
            state_d       = IDLE;
         end
         default: state_d = IDLE;
      endcase
   end

   // word address within the line, stable while the request waits
   assign mem_req_addr_o = miss_paddr_i + paddr_t'({beat_i, 2'b00});

   assign cmd_ready_o = (state_q == IDLE) & ~miss_i;

endmodule

// ==== fe_itlb.sv ====
// Fully associative instruction TLB.
// Entries are written by the ITLB_FILL backend command, reusing an entry
// with the same vpn or else the round-robin victim. The fetch PC is
// translated combinationally in the cycle it is offered.
`timescale 1ns/1ns

module fe_itlb
   import fe_pkg::*;
#(
   parameter int ITLB_ENTRIES = 4
) (
   input  logic       clk_i,
   input  logic       rst_n_i,
   input  logic       cmd_v_i,
   input  logic       cmd_ready_i,
   input  fe_opcode_e cmd_op_i,
   input  vaddr_t     cmd_vaddr_i,
   input  ppn_t       cmd_ppn_i,
   input  vaddr_t     fetch_pc_i,
   output logic       tlb_hit_o,
   output ppn_t       tlb_ppn_o
);

   localparam int PTR_W = (ITLB_ENTRIES > 1) ? $clog2(ITLB_ENTRIES) : 1;

   logic [ITLB_ENTRIES-1:0] entry_v;
   vpn_t                    entry_vpn [ITLB_ENTRIES];
   ppn_t                    entry_ppn [ITLB_ENTRIES];
   logic [PTR_W-1:0]        rr_ptr;
   logic [PTR_W-1:0]        fill_idx;
   logic                    fill;
   logic                    fill_match;
   vpn_t                    fill_vpn;
   vpn_t                    fetch_vpn;

   assign fill      = cmd_v_i & cmd_ready_i & (cmd_op_i == FE_OP_ITLB_FILL);
   assign fill_vpn  = cmd_vaddr_i[31:12];
   assign fetch_vpn = fetch_pc_i[31:12];

   // same vpn already present wins over the round-robin victim
   always_comb begin
      fill_match = 1'b0;
      fill_idx   = rr_ptr;
      for (int i = 0; i < ITLB_ENTRIES; i++) begin
         if (entry_v[i] && (entry_vpn[i] == fill_vpn)) begin
            fill_match = 1'b1;
            fill_idx   = PTR_W'(i);
         end
      end
   end

   always_comb begin
      tlb_hit_o = 1'b0;
      tlb_ppn_o = '0;
      for (int i = 0; i < ITLB_ENTRIES; i++) begin
         if (entry_v[i] && (entry_vpn[i] == fetch_vpn)) begin
            tlb_hit_o = 1'b1;
            tlb_ppn_o = entry_ppn[i];
         end
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         entry_v <= '0;
         rr_ptr  <= '0;
      end else if (fill) begin
         entry_v[fill_idx] <= 1'b1;
         if (!fill_match) begin
            rr_ptr <= (rr_ptr == PTR_W'(ITLB_ENTRIES - 1)) ? '0 : rr_ptr + 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (fill) begin
         entry_vpn[fill_idx] <= fill_vpn;
         entry_ppn[fill_idx] <= cmd_ppn_i;
      end
   end

endmodule

// ==== fe_pc_gen.sv ====
// Program counter of the front end.
// Offers the PC for fetch, steps it by 4 on each accepted fetch and
// loads the target of a backend redirect, pulsing flush in that cycle.
`timescale 1ns/1ns

module fe_pc_gen
   import fe_pkg::*;
#(
   parameter vaddr_t FIRST_PC = 32'h0000_1000
) (
   input  logic       clk_i,
   input  logic       rst_n_i,
   input  logic       cmd_v_i,
   input  logic       cmd_ready_i,
   input  fe_opcode_e cmd_op_i,
   input  vaddr_t     cmd_vaddr_i,
   input  logic       fetch_ready_i,
   output vaddr_t     fetch_pc_o,
   output logic       fetch_v_o,
   output logic       flush_o
);

   vaddr_t pc_q;
   logic   redirect;
   logic   advance;

   assign redirect = cmd_v_i & cmd_ready_i & (cmd_op_i == FE_OP_REDIRECT);

   // the current pc is dead in the redirect cycle
   assign fetch_v_o = ~redirect;
   assign flush_o   = redirect;

   // a held or stopped fetch stage keeps fetch_ready_i low
   assign advance = fetch_v_o & fetch_ready_i;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         pc_q <= FIRST_PC;
      end else if (redirect) begin
         pc_q <= cmd_vaddr_i;
      end else if (advance) begin
         pc_q <= pc_q + 32'd4;
      end
   end

   assign fetch_pc_o = pc_q;

endmodule

// ==== fe_icache.sv ====
// Direct-mapped instruction cache, virtually indexed and physically tagged,
// with the fetch stage register in front of the fetch queue.
// A TLB miss leaves as an exception entry and stops fetch until a flush.
// A tag miss raises miss_o until the refill FSM has filled the line.
`timescale 1ns/1ns

module fe_icache
   import fe_pkg::*;
#(
   parameter int ICACHE_SETS = 16
) (
   input  logic       clk_i,
   input  logic       rst_n_i,
   input  vaddr_t     fetch_pc_i,
   input  logic       fetch_v_i,
   input  logic       tlb_hit_i,
   input  ppn_t       tlb_ppn_i,
   input  logic       flush_i,
   input  logic       cmd_v_i,
   input  logic       cmd_ready_i,
   input  fe_opcode_e cmd_op_i,
   input  beat_t      beat_i,
   input  logic       refill_done_i,
   input  logic       mem_resp_v_i,
   input  instr_t     mem_resp_data_i,
   input  logic       queue_ready_i,
   output logic       fetch_ready_o,
   output logic       miss_o,
   output paddr_t     miss_paddr_o,
   output logic       queue_v_o,
   output vaddr_t     queue_pc_o,
   output instr_t     queue_instr_o,
   output fe_exc_e    queue_exc_o
);

   localparam int PA_W   = $bits(paddr_t);
   localparam int WORD_W = $clog2(LINE_WORDS);
   localparam int OFF_W  = WORD_W + 2;
   localparam int IDX_W  = $clog2(ICACHE_SETS);
   localparam int TAG_W  = PA_W - OFF_W - IDX_W;

   typedef logic [TAG_W-1:0] tag_t;

   tag_t                   tag_mem  [ICACHE_SETS];
   instr_t                 data_mem [ICACHE_SETS*LINE_WORDS];
   logic [ICACHE_SETS-1:0] line_v;

   logic             st_v;
   logic             st_hit;
   logic             st_stop;
   logic             st_held;
   vaddr_t           st_pc;
   ppn_t             st_ppn;
   paddr_t           st_paddr;
   logic [IDX_W-1:0] st_idx;
   tag_t             st_tag;
   logic             tag_hit;
   logic             fence;
   logic             accept;
   logic             q_fire;

   assign st_paddr = {st_ppn, st_pc[11:0]};
   assign st_idx   = st_pc[OFF_W +: IDX_W];
   assign st_tag   = st_paddr[PA_W-1:OFF_W+IDX_W];
   assign tag_hit  = line_v[st_idx] && (tag_mem[st_idx] == st_tag);
   assign fence    = cmd_v_i & cmd_ready_i & (cmd_op_i == FE_OP_ICACHE_FENCE);

   // st_held keeps a presented entry valid even if a fence drops its line
   assign queue_v_o    = st_v & (~st_hit | tag_hit | st_held);
   assign miss_o       = st_v & st_hit & ~tag_hit & ~st_held;
   assign miss_paddr_o = {st_paddr[PA_W-1:OFF_W], {OFF_W{1'b0}}};

   assign queue_pc_o    = st_pc;
   assign queue_exc_o   = st_hit ? FE_EXC_NONE : FE_EXC_ITLB_MISS;
   assign queue_instr_o = st_hit ? data_mem[{st_idx, st_pc[2 +: WORD_W]}] : '0;

   assign q_fire        = queue_v_o & queue_ready_i;
   assign fetch_ready_o = ~st_stop & (~st_v | q_fire);
   assign accept        = fetch_v_i & fetch_ready_o;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         st_v    <= 1'b0;
         st_stop <= 1'b0;
         st_held <= 1'b0;
      end else if (flush_i) begin
         st_v    <= 1'b0;
         st_stop <= 1'b0;
         st_held <= 1'b0;
      end else begin
         st_held <= queue_v_o & ~queue_ready_i;
         if (accept) begin
            st_v    <= 1'b1;
            st_stop <= ~tlb_hit_i;
         end else if (q_fire) begin
            st_v <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (accept) begin
         st_pc  <= fetch_pc_i;
         st_ppn <= tlb_ppn_i;
         st_hit <= tlb_hit_i;
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         line_v <= '0;
      end else if (fence) begin
         line_v <= '0;
      end else if (refill_done_i) begin
         line_v[st_idx] <= 1'b1;
      end
   end

   // refill writes the line of the held stage entry
   always_ff @(posedge clk_i) begin
      if (mem_resp_v_i) begin
         data_mem[{st_idx, beat_i}] <= mem_resp_data_i;
      end
      if (refill_done_i) begin
         tag_mem[st_idx] <= st_tag;
      end
   end

endmodule

// ==== fe_top.sv ====
// Top level of the instruction-fetch front end.
// Joins PC generator, ITLB, icache, refill FSM and beat counter behind the
// backend command port, the fetch queue port and one memory port.
`timescale 1ns/1ns

module fe_top
   import fe_pkg::*;
#(
   parameter int     ICACHE_SETS  = 16,
   parameter int     ITLB_ENTRIES = 4,
   parameter vaddr_t FIRST_PC     = 32'h0000_1000
) (
   input  logic       clk_i,
   input  logic       rst_n_i,
   input  logic       cmd_v_i,
   input  fe_opcode_e cmd_op_i,
   input  vaddr_t     cmd_vaddr_i,
   input  ppn_t       cmd_ppn_i,
   output logic       cmd_ready_o,
   output logic       queue_v_o,
   output vaddr_t     queue_pc_o,
   output instr_t     queue_instr_o,
   output fe_exc_e    queue_exc_o,
   input  logic       queue_ready_i,
   output logic       mem_req_v_o,
   output paddr_t     mem_req_addr_o,
   input  logic       mem_req_ready_i,
   input  logic       mem_resp_v_i,
   input  instr_t     mem_resp_data_i
);

   vaddr_t fetch_pc;
   logic   fetch_v;
   logic   fetch_ready;
   logic   flush;
   logic   tlb_hit;
   ppn_t   tlb_ppn;
   logic   miss;
   paddr_t miss_paddr;
   logic   beat_clear;
   logic   beat_inc;
   logic   refill_done;
   beat_t  beat;
   logic   beat_last;

   fe_pc_gen #(.FIRST_PC(FIRST_PC)) u_pc_gen (
      .clk_i(clk_i), .rst_n_i(rst_n_i),
      .cmd_v_i(cmd_v_i), .cmd_ready_i(cmd_ready_o),
      .cmd_op_i(cmd_op_i), .cmd_vaddr_i(cmd_vaddr_i),
      .fetch_ready_i(fetch_ready),
      .fetch_pc_o(fetch_pc), .fetch_v_o(fetch_v), .flush_o(flush)
   );

   fe_itlb #(.ITLB_ENTRIES(ITLB_ENTRIES)) u_itlb (
      .clk_i(clk_i), .rst_n_i(rst_n_i),
      .cmd_v_i(cmd_v_i), .cmd_ready_i(cmd_ready_o), .cmd_op_i(cmd_op_i),
      .cmd_vaddr_i(cmd_vaddr_i), .cmd_ppn_i(cmd_ppn_i),
      .fetch_pc_i(fetch_pc),
      .tlb_hit_o(tlb_hit), .tlb_ppn_o(tlb_ppn)
   );

   fe_icache #(.ICACHE_SETS(ICACHE_SETS)) u_icache (
      .clk_i(clk_i), .rst_n_i(rst_n_i),
      .fetch_pc_i(fetch_pc), .fetch_v_i(fetch_v),
      .tlb_hit_i(tlb_hit), .tlb_ppn_i(tlb_ppn), .flush_i(flush),
      .cmd_v_i(cmd_v_i), .cmd_ready_i(cmd_ready_o), .cmd_op_i(cmd_op_i),
      .beat_i(beat), .refill_done_i(refill_done),
      .mem_resp_v_i(mem_resp_v_i), .mem_resp_data_i(mem_resp_data_i),
      .queue_ready_i(queue_ready_i),
      .fetch_ready_o(fetch_ready), .miss_o(miss), .miss_paddr_o(miss_paddr),
      .queue_v_o(queue_v_o), .queue_pc_o(queue_pc_o),
      .queue_instr_o(queue_instr_o), .queue_exc_o(queue_exc_o)
   );

   fe_refill_fsm u_refill_fsm (
      .clk_i(clk_i), .rst_n_i(rst_n_i),
      .miss_i(miss), .miss_paddr_i(miss_paddr),
      .mem_req_ready_i(mem_req_ready_i), .mem_resp_v_i(mem_resp_v_i),
      .beat_i(beat), .beat_last_i(beat_last),
      .mem_req_v_o(mem_req_v_o), .mem_req_addr_o(mem_req_addr_o),
      .beat_clear_o(beat_clear), .beat_inc_o(beat_inc),
      .refill_done_o(refill_done), .cmd_ready_o(cmd_ready_o)
   );

   fe_beat_counter u_beat_counter (
      .clk_i(clk_i), .rst_n_i(rst_n_i),
      .clear_i(beat_clear), .inc_i(beat_inc),
      .beat_o(beat), .last_o(beat_last)
   );

endmodule

// ==== fe_assertions.sv ====
// Concurrent checks on the front-end handshakes and the refill port.
// Bound into fe_top.
`timescale 1ns/1ns

module fe_assertions
   import fe_pkg::*;
(
   input logic       clk_i,
   input logic       rst_n_i,
   input logic       cmd_v_i,
   input logic       cmd_ready_i,
   input fe_opcode_e cmd_op_i,
   input logic       queue_v_i,
   input logic       queue_ready_i,
   input vaddr_t     queue_pc_i,
   input instr_t     queue_instr_i,
   input fe_exc_e    queue_exc_i,
   input logic       mem_req_v_i,
   input logic       mem_req_ready_i,
   input paddr_t     mem_req_addr_i,
   input logic       mem_resp_v_i
);

   logic redirect;

   assign redirect = cmd_v_i & cmd_ready_i & (cmd_op_i == FE_OP_REDIRECT);

   // a taken redirect flushes a held entry
   queue_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      queue_v_i && !queue_ready_i && !redirect |=> queue_v_i && $stable(queue_pc_i)
         && $stable(queue_instr_i) && $stable(queue_exc_i))
      else $error("queue entry changed under back-pressure");

   mem_req_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      mem_req_v_i && !mem_req_ready_i |=> mem_req_v_i && $stable(mem_req_addr_i))
      else $error("memory request dropped or changed before acceptance");

   // responses only arrive while the refill still waits for them
   cmd_blocked: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      mem_req_v_i || mem_resp_v_i |-> !cmd_ready_i)
      else $error("command port ready during a refill");

endmodule

bind fe_top fe_assertions u_assertions (
   .clk_i(clk_i), .rst_n_i(rst_n_i),
   .cmd_v_i(cmd_v_i), .cmd_ready_i(cmd_ready_o), .cmd_op_i(cmd_op_i),
   .queue_v_i(queue_v_o), .queue_ready_i(queue_ready_i), .queue_pc_i(queue_pc_o),
   .queue_instr_i(queue_instr_o), .queue_exc_i(queue_exc_o),
   .mem_req_v_i(mem_req_v_o), .mem_req_ready_i(mem_req_ready_i),
   .mem_req_addr_i(mem_req_addr_o), .mem_resp_v_i(mem_resp_v_i)
);

// ==== tb_fe_top.sv ====
// Testbench for the instruction-fetch front end.
// Drives backend commands, answers the memory port with random latency
// and checks every fetch queue entry for pc, kind and instruction word.
`timescale 1ns/1ns

module tb_fe_top;
   import fe_pkg::*;

   localparam vaddr_t FIRST_PC = 32'h0000_1000;
   // ~110 entries, each at worst a 4-beat refill under random back-pressure
   localparam int CYCLE_LIMIT = 20000;

   logic       clk_i, rst_n_i;
   logic       cmd_v_i, cmd_ready_o;
   fe_opcode_e cmd_op_i;
   vaddr_t     cmd_vaddr_i, queue_pc_o;
   ppn_t       cmd_ppn_i;
   logic       queue_v_o, queue_ready_i;
   instr_t     queue_instr_o, mem_resp_data_i;
   fe_exc_e    queue_exc_o;
   logic       mem_req_v_o, mem_req_ready_i, mem_resp_v_i;
   paddr_t     mem_req_addr_o;

   ppn_t       page_map [vpn_t];
   logic [7:0] pattern_key = 8'h3C;
   vaddr_t     exp_pc = FIRST_PC;
   logic       stopped = 1'b0;
   logic       rand_ready = 1'b0;
   logic       resp_pending = 1'b0;
   paddr_t     resp_addr;
   int         resp_wait = 0;
   int         entry_count = 0;
   int         req_count = 0;
   int         req_before = 0;
   int         cycle_count = 0;
   int         value_errors = 0;
   int         other_errors = 0;

   fe_top u_dut (.*);

   always #5 clk_i = ~clk_i;

   // word stored at a physical address under the current pattern key
   function automatic instr_t ref_word(input paddr_t addr, input logic [7:0] key);
      return {addr[7:0] ^ key, addr};
   endfunction

   function automatic paddr_t ref_paddr(input vaddr_t pc);
      return {page_map[pc[31:12]], pc[11:0]};
   endfunction

   function automatic fe_exc_e ref_kind(input vaddr_t pc);
      return page_map.exists(pc[31:12]) ? FE_EXC_NONE : FE_EXC_ITLB_MISS;
   endfunction

   task automatic check_pc(input vaddr_t got, input vaddr_t exp);
      if (got !== exp) begin
         value_errors++;
         $display("[FAIL] %0t ns: queue pc %h, expected %h", $time, got, exp);
      end
   endtask

   task automatic check_instr(input instr_t got, input instr_t exp);
      if (got !== exp) begin
         value_errors++;
         $display("[FAIL] %0t ns: queue word %h, expected %h", $time, got, exp);
      end
   endtask

   task automatic check_exc(input fe_exc_e got, input fe_exc_e exp);
      if (got !== exp) begin
         value_errors++;
         $display("[FAIL] %0t ns: queue kind %s, expected %s", $time, got.name(), exp.name());
      end
   endtask

   task automatic send_cmd(input fe_opcode_e op, input vaddr_t vaddr, input ppn_t ppn);
      @(posedge clk_i);
      cmd_v_i     <= 1'b1;
      cmd_op_i    <= op;
      cmd_vaddr_i <= vaddr;
      cmd_ppn_i   <= ppn;
      @(negedge clk_i);
      while (!cmd_ready_o) @(negedge clk_i);
      @(posedge clk_i);
      cmd_v_i <= 1'b0;
   endtask

   task automatic wait_entries(input int n);
      int target;
      target = entry_count + n;
      while (entry_count < target) @(posedge clk_i);
   endtask

   // handshakes sampled mid-cycle take effect at the next rising edge
   always @(negedge clk_i) begin
      if (rst_n_i && queue_v_o && queue_ready_i) begin
         entry_count++;
         if (stopped) begin
            other_errors++;
            $display("%0t ns: entry %h came after an ITLB miss with no redirect",
                     $time, queue_pc_o);
         end else begin
            check_pc(queue_pc_o, exp_pc);
            check_exc(queue_exc_o, ref_kind(exp_pc));
            if (ref_kind(exp_pc) == FE_EXC_NONE) begin
               check_instr(queue_instr_o, ref_word(ref_paddr(exp_pc), pattern_key));
            end else begin
               stopped = 1'b1;
            end
            exp_pc = exp_pc + 32'd4;
         end
      end
      if (rst_n_i && cmd_v_i && cmd_ready_o) begin
         if (cmd_op_i == FE_OP_REDIRECT) begin
            exp_pc  = cmd_vaddr_i;
            stopped = 1'b0;
         end else if (cmd_op_i == FE_OP_ITLB_FILL) begin
            page_map[cmd_vaddr_i[31:12]] = cmd_ppn_i;
         end
      end
   end

   // memory model, one outstanding request answered 1 to 3 cycles later
   always @(negedge clk_i) begin
      if (rst_n_i && mem_req_v_o && mem_req_ready_i) begin
         if (resp_pending) begin
            other_errors++;
            $display("%0t ns: memory request sent while a response was pending", $time);
         end
         resp_pending = 1'b1;
         resp_addr    = mem_req_addr_o;
         resp_wait    = $urandom_range(3, 1);
         req_count++;
      end
   end

   always @(posedge clk_i) begin
      mem_resp_v_i    <= 1'b0;
      mem_req_ready_i <= ($urandom_range(3, 0) != 0);
      queue_ready_i   <= rand_ready ? 1'($urandom_range(1, 0)) : 1'b1;
      if (resp_pending) begin
         resp_wait--;
         if (resp_wait == 0) begin
            mem_resp_v_i    <= 1'b1;
            mem_resp_data_i <= ref_word(resp_addr, pattern_key);
            resp_pending = 1'b0;
         end
      end
   end

   always @(posedge clk_i) begin
      cycle_count++;
      if (cycle_count >= CYCLE_LIMIT) begin
         $display("timeout after %0d cycles, %0d value errors, %0d other errors",
                  cycle_count, value_errors, other_errors);
         $display("Done: errors found");
         $finish;
      end
   end

   initial begin
      void'($urandom(7));
      clk_i           = 1'b0;
      rst_n_i         = 1'b0;
      cmd_v_i         = 1'b0;
      cmd_op_i        = FE_OP_REDIRECT;
      cmd_vaddr_i     = '0;
      cmd_ppn_i       = '0;
      queue_ready_i   = 1'b1;
      mem_req_ready_i = 1'b0;
      mem_resp_v_i    = 1'b0;
      mem_resp_data_i = '0;
      repeat (2) @(posedge clk_i);
      rst_n_i <= 1'b1;

      // empty TLB, one exception entry and then silence
      wait_entries(1);
      repeat (20) @(posedge clk_i);

      send_cmd(FE_OP_ITLB_FILL, FIRST_PC, 12'h021);
      send_cmd(FE_OP_ITLB_FILL, 32'h0004_0000, 12'h0B5);
      send_cmd(FE_OP_REDIRECT, FIRST_PC, '0);
      wait_entries(24);

      rand_ready = 1'b1;
      wait_entries(40);
      rand_ready = 1'b0;

      // redirect while the stream is running
      send_cmd(FE_OP_REDIRECT, 32'h0000_1800, '0);
      wait_entries(12);

      // same cache indexes, different physical tags
      for (int i = 0; i < 4; i++) begin
         send_cmd(FE_OP_REDIRECT, (i % 2 == 0) ? 32'h0000_1100 : 32'h0004_0100, '0);
         wait_entries(6);
      end

      // stop on an unmapped page, then new memory contents and a fence
      send_cmd(FE_OP_REDIRECT, 32'h0000_3000, '0);
      wait_entries(1);
      pattern_key = 8'hA5;
      send_cmd(FE_OP_ICACHE_FENCE, '0, '0);
      req_before = req_count;
      // these two lines are still cached from the last pass above
      send_cmd(FE_OP_REDIRECT, 32'h0004_0100, '0);
      wait_entries(8);
      if (req_count - req_before < 2 * LINE_WORDS) begin
         other_errors++;
         $display("lines fetched after the fence were not refilled from memory");
      end

      repeat (10) @(posedge clk_i);
      $display("%0d value errors, %0d other errors", value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

// ==== build.f ====
fe_pkg.sv
fe_beat_counter.sv
fe_refill_fsm.sv
fe_itlb.sv
fe_pc_gen.sv
fe_icache.sv
fe_top.sv
fe_assertions.sv
tb_fe_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Compile the front-end testbench with Verilator, run it, check the result.
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f build.f \
      --top-module tb_fe_top -o tb_fe_top; then
   echo "verilator build failed"
   exit 1
fi

if ! output=$(./obj_dir/tb_fe_top); then
   echo "$output"
   echo "simulation exited with an error"
   exit 1
fi
echo "$output"

if grep -qx "Done: no errors" <<< "$output"; then
   exit 0
fi
exit 1
